// File: Bender.yml
package:
  name: id_tracker

sources:
  - tracker_pkg.sv
  - tracker_ifs.sv
  - lzc.sv
  - id_queue.sv
  - issue_ctrl.sv
  - retire_ctrl.sv
  - id_tracker.sv
  - target: test
    files:
      - tb_id_tracker.sv

// File: build.f
tracker_pkg.sv
tracker_ifs.sv
lzc.sv
id_queue.sv
issue_ctrl.sv
retire_ctrl.sv
id_tracker.sv
tb_id_tracker.sv

// File: id_queue.sv
// ID queue that keeps FIFO order per ID, with push, lookup or pop, and masked search ports
`timescale 1ns/1ps

module id_queue #(
    parameter int ID_WIDTH   = 1,
    parameter int CAPACITY   = 2,
    parameter int DATA_WIDTH = 1
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    queue_push_if.target    push_i,
    queue_lookup_if.target  lookup_i,
    queue_search_if.target  search_i
);

    // The head-tail table never needs more rows than there are IDs or entries
    localparam int N_IDS       = 2 ** ID_WIDTH;
    localparam int HT_CAPACITY = (N_IDS <= CAPACITY) ? N_IDS : CAPACITY;
    localparam int HT_IDX_W    = (HT_CAPACITY == 1) ? 1 : $clog2(HT_CAPACITY);
    localparam int LD_IDX_W    = (CAPACITY == 1) ? 1 : $clog2(CAPACITY);

    // Head-tail table, one row per live ID
    logic                  ht_free_q [HT_CAPACITY];
    logic [ID_WIDTH-1:0]   ht_id_q   [HT_CAPACITY];
    logic [LD_IDX_W-1:0]   ht_head_q [HT_CAPACITY];
    logic [LD_IDX_W-1:0]   ht_tail_q [HT_CAPACITY];

    // Linked data table, each entry points to the next younger one of its ID
    logic                  ld_free_q [CAPACITY];
    logic [DATA_WIDTH-1:0] ld_data_q [CAPACITY];
    logic [LD_IDX_W-1:0]   ld_next_q [CAPACITY];

    logic [HT_CAPACITY-1:0] ht_free_vec;
    logic [HT_CAPACITY-1:0] idx_match;
    logic [CAPACITY-1:0]    ld_free_vec;
    logic [CAPACITY-1:0]    search_match;
    logic [HT_IDX_W-1:0]    ht_free_idx;
    logic [HT_IDX_W-1:0]    match_idx;
    logic [LD_IDX_W-1:0]    ld_free_idx;
    logic [LD_IDX_W-1:0]    head_idx;
    logic [ID_WIDTH-1:0]    match_id;
    logic                   ld_full;
    logic                   id_hit;
    logic                   push_go;
    logic                   lookup_go;
    logic                   pop_go;

    for (genvar i = 0; i < HT_CAPACITY; i++) begin : gen_ht_vec
        assign ht_free_vec[i] = ht_free_q[i];
        assign idx_match[i]   = !ht_free_q[i] && (ht_id_q[i] == match_id);
    end

    for (genvar i = 0; i < CAPACITY; i++) begin : gen_ld_vec
        assign ld_free_vec[i] = ld_free_q[i];
        // Masked compare of one live entry against the search word
        assign search_match[i] = !ld_free_q[i] &&
            (((ld_data_q[i] ^ search_i.data) & search_i.mask) == '0);
    end

    // First free row of the head-tail table
    lzc #(.WIDTH(HT_CAPACITY)) i_ht_free_lzc (
        .in_i    (ht_free_vec),
        .cnt_o   (ht_free_idx),
        .empty_o ()
    );

    // First free data slot, and no free slot at all means the queue is full
    lzc #(.WIDTH(CAPACITY)) i_ld_free_lzc (
        .in_i    (ld_free_vec),
        .cnt_o   (ld_free_idx),
        .empty_o (ld_full)
    );

    // A push wins the slot whenever a data entry is free
    // With a free data entry, an unknown ID always finds a free head-tail row too
    assign push_go   = push_i.req && !ld_full;
    assign lookup_go = lookup_i.req && !push_go;
    assign match_id  = push_go ? push_i.id : lookup_i.id;

    // One-hot match vector to row index, at most one row matches
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < HT_CAPACITY; i++) begin
            if (idx_match[i]) begin
                match_idx = match_idx | HT_IDX_W'(i);
            end
        end
    end

    assign id_hit   = |idx_match;
    assign head_idx = ht_head_q[match_idx];
    assign pop_go   = lookup_go && lookup_i.pop && id_hit;

    assign push_i.gnt     = push_go;
    assign lookup_i.gnt   = lookup_go;
    assign lookup_i.valid = lookup_go && id_hit;
    assign lookup_i.data  = (lookup_go && id_hit) ? ld_data_q[head_idx] : '0;

    // Search runs beside the other two ports and never waits
    assign search_i.gnt = search_i.req;
    assign search_i.hit = search_i.req && (|search_match);

    // Every row and slot is free after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < HT_CAPACITY; i++) begin
                ht_free_q[i] <= 1'b1;
            end
            for (int i = 0; i < CAPACITY; i++) begin
                ld_free_q[i] <= 1'b1;
            end
        end else if (push_go) begin
            ld_free_q[ld_free_idx] <= 1'b0;
            if (!id_hit) begin
                ht_free_q[ht_free_idx] <= 1'b0;
            end
        end else if (pop_go) begin
            ld_free_q[head_idx] <= 1'b1;
            // Popping the last entry of an ID releases its row
            if (head_idx == ht_tail_q[match_idx]) begin
                ht_free_q[match_idx] <= 1'b1;
            end
        end
    end

    // Table payload and list links
    always_ff @(posedge clk_i) begin
        if (push_go) begin
            ld_data_q[ld_free_idx] <= push_i.data;
            if (!id_hit) begin
                // New ID opens a one-entry list
                ht_id_q[ht_free_idx]   <= push_i.id;
                ht_head_q[ht_free_idx] <= ld_free_idx;
                ht_tail_q[ht_free_idx] <= ld_free_idx;
            end else begin
                // Known ID links the new entry behind its tail
                ld_next_q[ht_tail_q[match_idx]] <= ld_free_idx;
                ht_tail_q[match_idx]            <= ld_free_idx;
            end
        end else if (pop_go && (head_idx != ht_tail_q[match_idx])) begin
            ht_head_q[match_idx] <= ld_next_q[head_idx];
        end
    end

endmodule

// File: id_tracker.sv
// Top level of the outstanding-transaction tracker with issue and retire handshake ports
`timescale 1ns/1ps

module id_tracker #(
    parameter int ID_WIDTH   = tracker_pkg::IdWidthDefault,
    parameter int CAPACITY   = tracker_pkg::CapacityDefault,
    parameter int ADDR_WIDTH = tracker_pkg::AddrWidthDefault
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // Issue port
    input  logic                             issue_req_i,
    input  logic [ID_WIDTH-1:0]              issue_id_i,
    input  logic [ADDR_WIDTH-1:0]            issue_addr_i,
    input  logic [tracker_pkg::LenWidth-1:0] issue_len_i,
    input  logic                             issue_match_len_i,
    output logic                             issue_ack_o,
    output logic                             issue_conflict_o,
    // Retire port
    input  logic                             retire_req_i,
    input  logic [ID_WIDTH-1:0]              retire_id_i,
    input  logic                             retire_pop_i,
    output logic                             retire_ack_o,
    output logic                             retire_hit_o,
    output logic [ADDR_WIDTH-1:0]            retire_addr_o,
    output logic [tracker_pkg::LenWidth-1:0] retire_len_o
);

    // Stored word is address above length
    localparam int DATA_WIDTH = ADDR_WIDTH + tracker_pkg::LenWidth;

    queue_push_if #(.ID_WIDTH(ID_WIDTH), .DATA_WIDTH(DATA_WIDTH)) push_bus ();
    queue_lookup_if #(.ID_WIDTH(ID_WIDTH), .DATA_WIDTH(DATA_WIDTH)) lookup_bus ();
    queue_search_if #(.DATA_WIDTH(DATA_WIDTH)) search_bus ();

    issue_ctrl #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) i_issue_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .issue_req_i       (issue_req_i),
        .issue_id_i        (issue_id_i),
        .issue_addr_i      (issue_addr_i),
        .issue_len_i       (issue_len_i),
        .issue_match_len_i (issue_match_len_i),
        .issue_ack_o       (issue_ack_o),
        .issue_conflict_o  (issue_conflict_o),
        .push_o            (push_bus.initiator),
        .search_o          (search_bus.initiator)
    );

    retire_ctrl #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) i_retire_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .retire_req_i  (retire_req_i),
        .retire_id_i   (retire_id_i),
        .retire_pop_i  (retire_pop_i),
        .retire_ack_o  (retire_ack_o),
        .retire_hit_o  (retire_hit_o),
        .retire_addr_o (retire_addr_o),
        .retire_len_o  (retire_len_o),
        .lookup_o      (lookup_bus.initiator)
    );

    id_queue #(
        .ID_WIDTH   (ID_WIDTH),
        .CAPACITY   (CAPACITY),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_id_queue (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .push_i   (push_bus.target),
        .lookup_i (lookup_bus.target),
        .search_i (search_bus.target)
    );

endmodule

// File: issue_ctrl.sv
// Four-phase issue front end that searches for a conflicting address and then pushes
`timescale 1ns/1ps

module issue_ctrl #(
    parameter int ID_WIDTH   = 1,
    parameter int ADDR_WIDTH = 1
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          issue_req_i,
    input  logic [ID_WIDTH-1:0]           issue_id_i,
    input  logic [ADDR_WIDTH-1:0]         issue_addr_i,
    input  logic [tracker_pkg::LenWidth-1:0] issue_len_i,
    input  logic                          issue_match_len_i,
    output logic                          issue_ack_o,
    output logic                          issue_conflict_o,
    queue_push_if.initiator               push_o,
    queue_search_if.initiator             search_o
);

    localparam int DATA_WIDTH = ADDR_WIDTH + tracker_pkg::LenWidth;

    // State encoding of the issue FSM
    localparam logic [1:0] StIdle   = 2'd0;
    localparam logic [1:0] StSearch = 2'd1;
    localparam logic [1:0] StPush   = 2'd2;
    localparam logic [1:0] StAck    = 2'd3;

    logic [1:0]            state_q;
    logic                  conflict_q;
    logic                  match_len_q;
    logic [ID_WIDTH-1:0]   id_q;
    logic [DATA_WIDTH-1:0] word_q;

    // Request fields latched on acceptance
    always_ff @(posedge clk_i) begin
        if ((state_q == StIdle) && issue_req_i) begin
            id_q        <= issue_id_i;
            match_len_q <= issue_match_len_i;
            word_q[tracker_pkg::AddrLsb +: ADDR_WIDTH]           <= issue_addr_i;
            word_q[tracker_pkg::LenLsb +: tracker_pkg::LenWidth] <= issue_len_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= StIdle;
            conflict_q <= 1'b0;
        end else begin
            case (state_q)
                StIdle: if (issue_req_i) state_q <= StSearch;
                // The search result decides whether the push state pushes at all
                StSearch: begin
                    if (search_o.gnt) begin
                        conflict_q <= search_o.hit;
                        state_q    <= StPush;
                    end
                end
                // A full queue keeps the push pending here
                StPush: if (conflict_q || push_o.gnt) state_q <= StAck;
                default: if (!issue_req_i) state_q <= StIdle;
            endcase
        end
    end

    // Address bits always compare, length bits only on request
    always_comb begin
        search_o.mask = '0;
        search_o.mask[tracker_pkg::AddrLsb +: ADDR_WIDTH] = '1;
        search_o.mask[tracker_pkg::LenLsb +: tracker_pkg::LenWidth] =
            {tracker_pkg::LenWidth{match_len_q}};
    end

    assign search_o.req  = (state_q == StSearch);
    assign search_o.data = word_q;
    assign push_o.req    = (state_q == StPush) && !conflict_q;
    assign push_o.id     = id_q;
    assign push_o.data   = word_q;

    assign issue_ack_o      = (state_q == StAck);
    assign issue_conflict_o = conflict_q;

endmodule

// File: lzc.sv
// Trailing-zero counter that returns the index of the lowest set bit of a vector
`timescale 1ns/1ps

module lzc #(
    parameter int WIDTH = 2,
    // Index width, kept at one bit for a single-bit vector
    localparam int CNT_WIDTH = (WIDTH == 1) ? 1 : $clog2(WIDTH)
) (
    input  logic [WIDTH-1:0]     in_i,
    output logic [CNT_WIDTH-1:0] cnt_o,
    output logic                 empty_o
);

    logic [CNT_WIDTH-1:0] idx;
    logic                 found;

    // Scan from the top down so that the lowest set bit is the last one to win
    always_comb begin
        idx   = '0;
        found = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (in_i[i]) begin
                idx   = CNT_WIDTH'(i);
                found = 1'b1;
            end
        end
    end

    // An all-zero vector reports index zero together with the empty flag
    assign cnt_o   = idx;
    assign empty_o = !found;

endmodule

// File: retire_ctrl.sv
// Four-phase retire front end that looks up the oldest entry of an ID and holds the result
`timescale 1ns/1ps

module retire_ctrl #(
    parameter int ID_WIDTH   = 1,
    parameter int ADDR_WIDTH = 1
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             retire_req_i,
    input  logic [ID_WIDTH-1:0]              retire_id_i,
    input  logic                             retire_pop_i,
    output logic                             retire_ack_o,
    output logic                             retire_hit_o,
    output logic [ADDR_WIDTH-1:0]            retire_addr_o,
    output logic [tracker_pkg::LenWidth-1:0] retire_len_o,
    queue_lookup_if.initiator                lookup_o
);

    localparam int DATA_WIDTH = ADDR_WIDTH + tracker_pkg::LenWidth;

    localparam logic [1:0] StIdle   = 2'd0;
    localparam logic [1:0] StLookup = 2'd1;
    localparam logic [1:0] StAck    = 2'd2;

    logic [1:0]            state_q;
    logic                  hit_q;
    logic                  pop_q;
    logic [ID_WIDTH-1:0]   id_q;
    logic [DATA_WIDTH-1:0] data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= StIdle;
            hit_q   <= 1'b0;
        end else begin
            case (state_q)
                StIdle: if (retire_req_i) state_q <= StLookup;
                // A push in the same cycle holds the lookup off
                StLookup: begin
                    if (lookup_o.gnt) begin
                        hit_q   <= lookup_o.valid;
                        state_q <= StAck;
                    end
                end
                default: if (!retire_req_i) state_q <= StIdle;
            endcase
        end
    end

    // Request fields on acceptance and the entry word on grant
    always_ff @(posedge clk_i) begin
        if ((state_q == StIdle) && retire_req_i) begin
            id_q  <= retire_id_i;
            pop_q <= retire_pop_i;
        end
        if ((state_q == StLookup) && lookup_o.gnt) begin
            data_q <= lookup_o.data;
        end
    end

    assign lookup_o.req = (state_q == StLookup);
    assign lookup_o.id  = id_q;
    assign lookup_o.pop = pop_q;

    assign retire_ack_o  = (state_q == StAck);
    assign retire_hit_o  = hit_q;
    assign retire_addr_o = data_q[tracker_pkg::AddrLsb +: ADDR_WIDTH];
    assign retire_len_o  = data_q[tracker_pkg::LenLsb +: tracker_pkg::LenWidth];

endmodule

// File: tb_id_tracker.sv
// Directed testbench for the ID tracker, built from build.f with tb_id_tracker as top
`timescale 1ns/1ps

module tb_id_tracker;

    localparam int IdWidth       = tracker_pkg::IdWidthDefault;
    localparam int Capacity      = tracker_pkg::CapacityDefault;
    localparam int AddrWidth     = tracker_pkg::AddrWidthDefault;
    localparam int LenWidth      = tracker_pkg::LenWidth;
    localparam int TimeoutCycles = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 issue_req;
    logic [IdWidth-1:0]   issue_id;
    logic [AddrWidth-1:0] issue_addr;
    logic [LenWidth-1:0]  issue_len;
    logic                 issue_match_len;
    logic                 issue_ack;
    logic                 issue_conflict;
    logic                 retire_req;
    logic [IdWidth-1:0]   retire_id;
    logic                 retire_pop;
    logic                 retire_ack;
    logic                 retire_hit;
    logic [AddrWidth-1:0] retire_addr;
    logic [LenWidth-1:0]  retire_len;

    // Reference model, one slot per outstanding entry kept in issue order
    // The first slot with a given ID is the head of that ID's FIFO
    logic [IdWidth-1:0]   m_id   [$];
    logic [AddrWidth-1:0] m_addr [$];
    logic [LenWidth-1:0]  m_len  [$];

    logic [31:0] lfsr_state;

    id_tracker #(
        .ID_WIDTH   (IdWidth),
        .CAPACITY   (Capacity),
        .ADDR_WIDTH (AddrWidth)
    ) dut (
        .clk_i             (clk),
        .rst_ni            (rst_n),
        .issue_req_i       (issue_req),
        .issue_id_i        (issue_id),
        .issue_addr_i      (issue_addr),
        .issue_len_i       (issue_len),
        .issue_match_len_i (issue_match_len),
        .issue_ack_o       (issue_ack),
        .issue_conflict_o  (issue_conflict),
        .retire_req_i      (retire_req),
        .retire_id_i       (retire_id),
        .retire_pop_i      (retire_pop),
        .retire_ack_o      (retire_ack),
        .retire_hit_o      (retire_hit),
        .retire_addr_o     (retire_addr),
        .retire_len_o      (retire_len)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string reason);
        $display("%s at time %0t", reason, $time);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped after a mismatch");
        end
    endtask

    // Galois LFSR, stepped once for every bit handed out
    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    // Index of the oldest model entry of an ID, or -1 when the ID has none
    function automatic int model_find_id(input logic [IdWidth-1:0] id);
        for (int i = 0; i < m_id.size(); i++) begin
            if (m_id[i] == id) return i;
        end
        return -1;
    endfunction

    // A new issue conflicts with any outstanding entry of the same address,
    // and with match_len set the length has to agree as well
    function automatic logic model_conflict(input logic [AddrWidth-1:0] addr,
                                            input logic [LenWidth-1:0] len,
                                            input logic match_len);
        for (int i = 0; i < m_addr.size(); i++) begin
            if ((m_addr[i] == addr) && (!match_len || (m_len[i] == len))) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Random address that no outstanding entry holds yet
    function automatic logic [AddrWidth-1:0] fresh_addr();
        logic [AddrWidth-1:0] addr;
        addr = AddrWidth'(random_bits(AddrWidth));
        for (int k = 0; (k < 64) && model_conflict(addr, '0, 1'b0); k++) begin
            addr = AddrWidth'(random_bits(AddrWidth));
        end
        return addr;
    endfunction

    // Full four-phase issue transfer, checked against the model
    task automatic do_issue(input logic [IdWidth-1:0] id, input logic [AddrWidth-1:0] addr,
                            input logic [LenWidth-1:0] len, input logic match_len,
                            output logic conflict);
        logic expected;
        int   waited;
        expected = model_conflict(addr, len, match_len);
        @(negedge clk);
        issue_req       = 1'b1;
        issue_id        = id;
        issue_addr      = addr;
        issue_len       = len;
        issue_match_len = match_len;
        waited          = 0;
        while (issue_ack !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > TimeoutCycles) stop_run("Issue ack never went high");
        end
        conflict = issue_conflict;
        check_value(conflict, expected, "issue conflict flag");
        if (!expected) begin
            m_id.push_back(id);
            m_addr.push_back(addr);
            m_len.push_back(len);
        end
        issue_req = 1'b0;
        waited    = 0;
        while (issue_ack !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > TimeoutCycles) stop_run("Issue ack stayed high after req fell");
        end
    endtask

    // Full four-phase retire transfer, pop removes the model head as well
    task automatic do_retire(input logic [IdWidth-1:0] id, input logic pop);
        int idx;
        int waited;
        @(negedge clk);
        retire_req = 1'b1;
        retire_id  = id;
        retire_pop = pop;
        waited     = 0;
        while (retire_ack !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > TimeoutCycles) stop_run("Retire ack never went high");
        end
        idx = model_find_id(id);
        check_value(retire_hit, idx >= 0, "retire hit flag");
        if (idx >= 0) begin
            check_value(retire_addr, m_addr[idx], "retire address");
            check_value(retire_len, m_len[idx], "retire length");
            if (pop) begin
                m_id.delete(idx);
                m_addr.delete(idx);
                m_len.delete(idx);
            end
        end
        retire_req = 1'b0;
        waited     = 0;
        while (retire_ack !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > TimeoutCycles) stop_run("Retire ack stayed high after req fell");
        end
    endtask

    // Pops every outstanding entry, oldest first
    task automatic drain_all();
        while (m_id.size() > 0) begin
            do_retire(m_id[0], 1'b1);
        end
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_value(issue_ack, 1'b0, "issue ack in reset");
            check_value(retire_ack, 1'b0, "retire ack in reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value(issue_ack, 1'b0, "issue ack after reset");
        check_value(retire_ack, 1'b0, "retire ack after reset");
        // The queue starts empty, so no ID can hit
        for (int i = 0; i < 2 ** IdWidth; i++) begin
            do_retire(IdWidth'(i), 1'b1);
        end
    endtask

    task automatic test_same_id_order();
        logic c;
        for (int i = 0; i < 4; i++) begin
            do_issue(3'd3, fresh_addr(), LenWidth'(random_bits(LenWidth)), 1'b0, c);
        end
        // Peeking twice must show the same oldest entry
        do_retire(3'd3, 1'b0);
        do_retire(3'd3, 1'b0);
        for (int i = 0; i < 4; i++) begin
            do_retire(3'd3, 1'b1);
        end
        do_retire(3'd3, 1'b1);
    endtask

    task automatic test_interleaved_ids();
        logic c;
        logic [IdWidth-1:0] issue_order [6];
        logic [IdWidth-1:0] retire_order [6];
        issue_order  = '{3'd1, 3'd4, 3'd1, 3'd6, 3'd4, 3'd6};
        retire_order = '{3'd6, 3'd1, 3'd4, 3'd6, 3'd4, 3'd1};
        for (int i = 0; i < 6; i++) begin
            do_issue(issue_order[i], fresh_addr(), LenWidth'(random_bits(LenWidth)), 1'b0, c);
        end
        for (int i = 0; i < 6; i++) begin
            do_retire(retire_order[i], 1'b1);
        end
    endtask

    task automatic test_address_conflict();
        logic c;
        logic [AddrWidth-1:0] a;
        a = fresh_addr();
        do_issue(3'd2, a, 4'd3, 1'b0, c);
        check_value(c, 1'b0, "first issue of an address");
        // The refused length differs from the one ID 5 stores later
        do_issue(3'd5, a, 4'd9, 1'b0, c);
        check_value(c, 1'b1, "repeated address");
        do_issue(3'd5, a, 4'd7, 1'b1, c);
        check_value(c, 1'b0, "length-qualified issue with another length");
        do_issue(3'd6, a, 4'd3, 1'b1, c);
        check_value(c, 1'b1, "length-qualified issue with the same length");
        // ID 6 was refused, so only IDs 2 and 5 hold the address
        do_retire(3'd6, 1'b1);
        do_retire(3'd5, 1'b1);
        do_retire(3'd2, 1'b1);
        do_issue(3'd6, a, 4'd3, 1'b0, c);
        check_value(c, 1'b0, "address issued again after its pop");
        drain_all();
    endtask

    task automatic test_full_backpressure();
        logic c;
        for (int i = 0; i < Capacity; i++) begin
            do_issue(IdWidth'(i % 3), fresh_addr(), LenWidth'(random_bits(LenWidth)), 1'b0, c);
            check_value(c, 1'b0, "issue while filling the queue");
        end
        fork
            do_issue(3'd5, fresh_addr(), 4'd9, 1'b0, c);
            begin
                // The extra issue has to stall until an entry is freed
                for (int k = 0; k < 10; k++) begin
                    @(negedge clk);
                    check_value(issue_ack, 1'b0, "issue ack with a full queue");
                end
                do_retire(3'd0, 1'b1);
            end
        join
        check_value(c, 1'b0, "issue completed after back-pressure");
        drain_all();
    endtask

    initial begin
        lfsr_state      = 32'h8652b86d;
        rst_n           = 1'b0;
        issue_req       = 1'b0;
        issue_id        = '0;
        issue_addr      = '0;
        issue_len       = '0;
        issue_match_len = 1'b0;
        retire_req      = 1'b0;
        retire_id       = '0;
        retire_pop      = 1'b0;
        test_reset();
        test_same_id_order();
        test_interleaved_ids();
        test_address_conflict();
        test_full_backpressure();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tracker_ifs.sv
// Queue access interfaces between the tracker front ends and the ID queue
`timescale 1ns/1ps

// Push channel, transfer happens when req and gnt are both high
interface queue_push_if #(
    parameter int ID_WIDTH   = 1,
    parameter int DATA_WIDTH = 1
) ();
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic                  req;
    logic                  gnt;

    modport initiator (output id, data, req, input gnt);
    modport target (input id, data, req, output gnt);
endinterface

// Lookup channel, which reads or pops the oldest entry of one ID
interface queue_lookup_if #(
    parameter int ID_WIDTH   = 1,
    parameter int DATA_WIDTH = 1
) ();
    logic [ID_WIDTH-1:0]   id;
    logic                  pop;
    logic                  req;
    logic [DATA_WIDTH-1:0] data;
    // Valid is low when the ID had no entry in the queue
    logic                  valid;
    logic                  gnt;

    modport initiator (output id, pop, req, input data, valid, gnt);
    modport target (input id, pop, req, output data, valid, gnt);
endinterface

// Masked search channel, answered in the same cycle
interface queue_search_if #(
    parameter int DATA_WIDTH = 1
) ();
    logic [DATA_WIDTH-1:0] data;
    // Only bits set in the mask take part in the compare
    logic [DATA_WIDTH-1:0] mask;
    logic                  req;
    logic                  hit;
    logic                  gnt;

    modport initiator (output data, mask, req, input hit, gnt);
    modport target (input data, mask, req, output hit, gnt);
endinterface

// File: tracker_pkg.sv
// Shared widths and stored-word layout for the outstanding-transaction tracker
package tracker_pkg;

    // Default ID width of the tracker, in bits
    localparam int IdWidthDefault = 3;

    // Default number of entries in the ID queue
    localparam int CapacityDefault = 6;

    // Default address width, in bits
    localparam int AddrWidthDefault = 16;

    // Burst length width, which is the same for every configuration
    localparam int LenWidth = 4;

    // A stored word keeps the length in its low bits
    localparam int LenLsb = 0;

    // The address sits directly above the length field
    localparam int AddrLsb = LenLsb + LenWidth;

endpackage
